/* Makefile */
# Verilator lint and simulation of the FP compare unit

VERILATOR  ?= verilator
FILELIST   ?= filelist.f
TB_TOP     ?= fpCompareUnitTb
RTL_TOP    ?= fpCompareUnit
BUILD_DIR  ?= obj_dir
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --timing --assert
PASS_MSG   ?= Simulation PASSED
SOURCES    := $(wildcard logic/*.sv tests/*.sv tests/*.svh)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(BUILD_DIR)/V$(TB_TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TB_TOP)
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* filelist.f */
+incdir+tests
logic/fpFormatPkg.sv
logic/fpCmpPkg.sv
logic/magCompare.sv
logic/orderDecide.sv
logic/fpClassify.sv
logic/fpCompareCore.sv
logic/singleLaneCompare.sv
logic/cmpResultPack.sv
logic/fpCompareUnit.sv
tests/fpCompareUnitTb.sv

/* logic/cmpResultPack.sv */
/*
  Compare result register.
  Registers the main-lane flags, evaluates the condition per lane and
  registers the packed lane-mask word with its valid bit.
*/
`timescale 1ns/1ns
`default_nettype none

module cmpResultPack (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [3:0]                    mainFlags,
  input  logic [3:0]                    hiFlags,
  input  fpCmpPkg::cmpCond              cond,
  input  logic                          paired,
  input  logic                          vec,
  output logic [3:0]                    flags,
  output logic [fpFormatPkg::MASK_W-1:0] maskOut,
  output logic                          maskValid
);

  import fpFormatPkg::*;
  import fpCmpPkg::*;

  logic              loRes, hiRes;
  logic [MASK_W-1:0] maskNext;

  function automatic logic condHit(input cmpCond c, input logic [3:0] f);
    case (c)
      condEq:  condHit = f[flagEq];
      condNe:  condHit = ~f[flagEq];
      condLt:  condHit = f[flagLt];
      default: condHit = f[flagGt] | f[flagEq]; // condGe
    endcase
  endfunction

  assign loRes = condHit(cond, mainFlags);
  assign hiRes = condHit(cond, paired ? hiFlags : mainFlags);

  assign maskNext = (paired | vec) ?
    {(vec ? ptypeDbl : ptypeSngl), {LANE_W{hiRes}}, {LANE_W{loRes}}} : '0;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (rst) begin
      flags     <= '0;
      maskOut   <= '0;
      maskValid <= 1'b0;
    end else begin
      flags     <= mainFlags;
      maskOut   <= maskNext;
      maskValid <= paired | vec;  // mask only for vector and paired ops
    end
  end

endmodule

`default_nettype wire

/* logic/fpClassify.sv */
/*
  Operand classifier.
  Picks sign, exponent and fraction by format, widens the exponent to
  15 bits keeping its order and left-aligns the fraction to 64 bits.
*/
`timescale 1ns/1ns
`default_nettype none

module fpClassify (
  input  logic [fpFormatPkg::OPER_W-1:0] op,
  input  fpFormatPkg::fpFmt              fmt,
  output logic                           sign,
  output logic [fpFormatPkg::MAG_W-1:0]  mag,
  output logic                           isZero,
  output logic                           isNan
);

  import fpFormatPkg::*;

  logic [EXP_W-1:0]  expWide;
  logic [FRAC_W-1:0] fracAlign;
  logic              expZero;
  logic              expOnes;
  logic              fracZero;   // explicit integer bit not included

  always_comb begin
    case (fmt)
      fmtSingle: begin
        sign      = op[31];
        expZero   = ~|op[30:23];
        expOnes   = &op[30:23];
        fracZero  = ~|op[22:0];
        expWide   = {op[30], {(EXP_W-SNG_EXP_W){~op[30]}}, op[29:23]};
        fracAlign = {~expZero, op[22:0], {(FRAC_W-SNG_FRAC_W-1){1'b0}}};
      end
      fmtDouble: begin
        sign      = op[63];
        expZero   = ~|op[62:52];
        expOnes   = &op[62:52];
        fracZero  = ~|op[51:0];
        expWide   = {op[62], {(EXP_W-DBL_EXP_W){~op[62]}}, op[61:52]};
        fracAlign = {~expZero, op[51:0], {(FRAC_W-DBL_FRAC_W-1){1'b0}}};
      end
      default: begin                // extended, integer bit already explicit
        sign      = op[79];
        expZero   = ~|op[78:64];
        expOnes   = &op[78:64];
        fracZero  = ~|op[62:0];
        expWide   = op[78:64];
        fracAlign = op[63:0];
      end
    endcase
  end

  assign mag    = {expWide, fracAlign};
  assign isZero = expZero & fracZero;
  assign isNan  = expOnes & ~fracZero; // infinities have zero fraction

endmodule

`default_nettype wire

/* logic/fpCmpPkg.sv */
/*
  FP compare opcodes and flag layout.
  Condition codes for mask-producing compares and bit positions
  of the 4-bit ordering flags word.
*/
`default_nettype none

package fpCmpPkg;

  typedef enum logic [1:0] {
    condEq = 2'd0,
    condNe = 2'd1, // true when unordered too
    condLt = 2'd2,
    condGe = 2'd3
  } cmpCond;

  // one-hot ordering flags
  localparam int flagUnord = 0;
  localparam int flagEq    = 1;
  localparam int flagLt    = 2;
  localparam int flagGt    = 3;

endpackage

`default_nettype wire

/* logic/fpCompareCore.sv */
/*
  Main-lane FP compare.
  Classifies both operands in the effective format, then runs one
  magnitude compare and the ordering decision.
*/
`timescale 1ns/1ns
`default_nettype none

module fpCompareCore #(
  parameter int MAG_WIDTH = 79
) (
  input  logic [fpFormatPkg::OPER_W-1:0] opA,
  input  logic [fpFormatPkg::OPER_W-1:0] opB,
  input  fpFormatPkg::fpFmt              fmt,
  input  logic                           paired,
  output logic [3:0]                     flags
);

  import fpFormatPkg::*;

  fpFmt                 effFmt;
  logic                 signA, signB;
  logic [MAG_WIDTH-1:0] magA, magB;
  logic                 zeroA, zeroB;
  logic                 nanA, nanB;
  logic                 magGe, magEq;

  assign effFmt = paired ? fmtSingle : fmt; // low paired single

  fpClassify classA_i (
    .op(opA), .fmt(effFmt), .sign(signA), .mag(magA), .isZero(zeroA), .isNan(nanA)
  );

  fpClassify classB_i (
    .op(opB), .fmt(effFmt), .sign(signB), .mag(magB), .isZero(zeroB), .isNan(nanB)
  );

  magCompare #(.WIDTH(MAG_WIDTH)) magCmp_i (
    .a(magA), .b(magB), .ge(magGe), .eq(magEq)
  );

  orderDecide order_i (
    .signA(signA), .signB(signB), .zeroA(zeroA), .zeroB(zeroB),
    .nanA(nanA), .nanB(nanB), .magGe(magGe), .magEq(magEq),
    .flags(flags)
  );

endmodule

`default_nettype wire

/* logic/fpCompareUnit.sv */
/*
  FP compare unit top level.
  Main lane, high paired-single lane and the result register.
*/
`timescale 1ns/1ns
`default_nettype none

module fpCompareUnit #(
  parameter int MAG_WIDTH = 79
) (
  input  logic                           clk,
  input  logic                           rst,
  input  logic [fpFormatPkg::OPER_W-1:0] opA,
  input  logic [fpFormatPkg::OPER_W-1:0] opB,
  input  fpFormatPkg::fpFmt              fmt,
  input  logic                           paired,
  input  logic                           vec,
  input  fpCmpPkg::cmpCond               cond,
  output logic [3:0]                     flags,
  output logic [fpFormatPkg::MASK_W-1:0] maskOut,
  output logic                           maskValid
);

  import fpFormatPkg::*;

  logic [3:0] mainFlags;
  logic [3:0] hiFlags;

  fpCompareCore #(.MAG_WIDTH(MAG_WIDTH)) core_i (
    .opA(opA), .opB(opB), .fmt(fmt), .paired(paired), .flags(mainFlags)
  );

  singleLaneCompare #(.MAG_WIDTH(SNG_MAG_W)) hiLane_i (
    .hiA(opA[63:32]),   // upper paired single
    .hiB(opB[63:32]),
    .flags(hiFlags)
  );

  cmpResultPack pack_i (
    .clk(clk),
    .rst(rst),
    .mainFlags(mainFlags),
    .hiFlags(hiFlags),
    .cond(cond),
    .paired(paired),
    .vec(vec),
    .flags(flags),
    .maskOut(maskOut),
    .maskValid(maskValid)
  );

endmodule

`default_nettype wire

/* logic/fpFormatPkg.sv */
/*
  FP operand format definitions.
  Format selector, field widths of the single, double and extended
  layouts, and the packed-type codes of the lane-mask word.
*/
`default_nettype none

package fpFormatPkg;

  typedef enum logic [1:0] {
    fmtSingle = 2'd0,
    fmtDouble = 2'd1,
    fmtExt    = 2'd2
  } fpFmt;

  localparam int OPER_W     = 80; // extended layout is the widest
  localparam int EXP_W      = 15; // widened exponent
  localparam int FRAC_W     = 64; // left-aligned fraction incl. integer bit
  localparam int MAG_W      = EXP_W + FRAC_W;
  localparam int SNG_EXP_W  = 8;
  localparam int SNG_FRAC_W = 23;
  localparam int SNG_MAG_W  = SNG_EXP_W + SNG_FRAC_W;
  localparam int DBL_EXP_W  = 11;
  localparam int DBL_FRAC_W = 52;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int MASK_W = 68;
  localparam int LANE_W = 33;             // copies of one lane result
  localparam logic [1:0] ptypeSngl = 2'd1;
  localparam logic [1:0] ptypeDbl  = 2'd2;

endpackage

`default_nettype wire

/* logic/magCompare.sv */
/*
  Unsigned magnitude comparator.
  Carry out of a + ~b + 1 from a Kogge-Stone prefix network gives a >= b,
  equality comes from a separate reduction.
*/
`timescale 1ns/1ns
`default_nettype none

module magCompare #(
  parameter int WIDTH = 79
) (
  input  logic [WIDTH-1:0] a,
  input  logic [WIDTH-1:0] b,
  output logic             ge,
  output logic             eq
);

  localparam int LEVELS = $clog2(WIDTH);

  logic [WIDTH-1:0] gen;
  logic [WIDTH-1:0] prop;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // prefix tree, one merge per level
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    // carry-in of one folded into bit 0 generate
    gen  = {a[WIDTH-1:1] & ~b[WIDTH-1:1], a[0] | ~b[0]};
    prop = a | ~b;
    for (int lvl = 0; lvl < LEVELS; lvl++) begin
      gen  = gen | (prop & (gen << (1 << lvl)));
      prop = prop & (prop << (1 << lvl)); // low bits are already final
    end
  end

  assign ge = gen[WIDTH-1];     // carry out
  assign eq = ~|(a ^ b);

endmodule

`default_nettype wire

/* logic/orderDecide.sv */
/*
  Ordering decision.
  Combines sign, zero and NaN class with magnitude order into one-hot
  unordered / eq / lt / gt flags.
*/
`timescale 1ns/1ns
`default_nettype none

module orderDecide (
  input  logic       signA,
  input  logic       signB,
  input  logic       zeroA,
  input  logic       zeroB,
  input  logic       nanA,
  input  logic       nanB,
  input  logic       magGe,
  input  logic       magEq,
  output logic [3:0] flags
);

  import fpCmpPkg::*;

  always_comb begin
    flags = '0;
    if (nanA | nanB) begin
      flags[flagUnord] = 1'b1;
    end else if (zeroA & zeroB) begin
      flags[flagEq] = 1'b1;        // +0 == -0
    end else if (signA != signB) begin
      if (signB) flags[flagGt] = 1'b1; // positive side wins
      else flags[flagLt] = 1'b1;
    end else if (magEq) begin
      flags[flagEq] = 1'b1;
    end else if (magGe ^ signA) begin
      flags[flagGt] = 1'b1;        // negatives reverse the order
    end else begin
      flags[flagLt] = 1'b1;
    end
  end

endmodule

`default_nettype wire

/* logic/singleLaneCompare.sv */
/*
  High paired-single lane compare.
  Raw 31-bit single magnitude already orders correctly, so no widening.
*/
`timescale 1ns/1ns
`default_nettype none

module singleLaneCompare #(
  parameter int MAG_WIDTH = 31
) (
  input  logic [31:0] hiA,
  input  logic [31:0] hiB,
  output logic [3:0]  flags
);

  import fpFormatPkg::*;

  logic [MAG_WIDTH-1:0] magA, magB;
  logic                 zeroA, zeroB;
  logic                 nanA, nanB;
  logic                 magGe, magEq;

  assign magA = hiA[MAG_WIDTH-1:0];
  assign magB = hiB[MAG_WIDTH-1:0];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign zeroA = ~|hiA[SNG_MAG_W-1:0];
  assign zeroB = ~|hiB[SNG_MAG_W-1:0];
  assign nanA  = (&hiA[SNG_MAG_W-1:SNG_FRAC_W]) & (|hiA[SNG_FRAC_W-1:0]);
  assign nanB  = (&hiB[SNG_MAG_W-1:SNG_FRAC_W]) & (|hiB[SNG_FRAC_W-1:0]);

  magCompare #(.WIDTH(MAG_WIDTH)) magCmp_i (
    .a(magA), .b(magB), .ge(magGe), .eq(magEq)
  );

  orderDecide order_i (
    .signA(hiA[31]), .signB(hiB[31]),   // sign bits
    .zeroA(zeroA), .zeroB(zeroB),
    .nanA(nanA), .nanB(nanB),
    .magGe(magGe), .magEq(magEq),
    .flags(flags)
  );

endmodule

`default_nettype wire

/* tests/fpCmpModel.svh */
/*
  Reference model of the FP compare unit.
  Orders both operands by signed value and builds the expected
  ordering flags and packed lane-mask word.
*/
`ifndef FP_CMP_MODEL_SVH
`define FP_CMP_MODEL_SVH

// sign, raw magnitude and class of one operand
function automatic void decodeOperand(input logic [OPER_W-1:0] op, input fpFmt f,
                                      output logic sign, output logic [MAG_W-1:0] mag,
                                      output logic isZero, output logic isNan);
  case (f)
    fmtSingle: begin
      sign   = op[31];
      mag    = {48'b0, op[30:0]};
      isZero = (op[30:0] == '0);
      isNan  = (op[30:23] == '1) && (op[22:0] != '0);
    end
    fmtDouble: begin
      sign   = op[63];
      mag    = {16'b0, op[62:0]};
      isZero = (op[62:0] == '0);
      isNan  = (op[62:52] == '1) && (op[51:0] != '0);
    end
    default: begin
      sign   = op[79];
      mag    = op[78:0];                 // exponent, integer bit, fraction
      isZero = (op[78:64] == '0) && (op[62:0] == '0);
      isNan  = (op[78:64] == '1) && (op[62:0] != '0);
    end
  endcase
endfunction

function automatic logic [3:0] compareValues(input logic [OPER_W-1:0] a,
                                             input logic [OPER_W-1:0] b, input fpFmt f);
  logic                    sA, sB, zA, zB, nA, nB;
  logic [MAG_W-1:0]        mA, mB;
  logic signed [MAG_W+1:0] keyA, keyB;
  logic [3:0]              res;
  decodeOperand(a, f, sA, mA, zA, nA);
  decodeOperand(b, f, sB, mB, zB, nB);
  // sign-magnitude to two's complement, both zeros land on 0
  keyA = sA ? -$signed({2'b00, mA}) : $signed({2'b00, mA});
  keyB = sB ? -$signed({2'b00, mB}) : $signed({2'b00, mB});
  res  = '0;
  if (nA || nB) res[flagUnord] = 1'b1;
  else if (keyA == keyB) res[flagEq] = 1'b1;
  else if (keyA < keyB) res[flagLt] = 1'b1;
  else res[flagGt] = 1'b1;
  return res;
endfunction

function automatic logic [3:0] refFlags(input logic [OPER_W-1:0] a,
                                        input logic [OPER_W-1:0] b,
                                        input fpFmt f, input logic paired);
  return compareValues(a, b, paired ? fmtSingle : f);  // paired uses low single
endfunction

function automatic logic condTrue(input cmpCond c, input logic [3:0] fl);
  case (c)
    condEq:  return fl[flagEq];
    condNe:  return !fl[flagEq];
    condLt:  return fl[flagLt];
    default: return fl[flagGt] || fl[flagEq];
  endcase
endfunction

function automatic logic [MASK_W-1:0] refMask(input logic [OPER_W-1:0] a,
                                              input logic [OPER_W-1:0] b, input fpFmt f,
                                              input logic paired, input logic vec,
                                              input cmpCond c);
  logic lo, hi;
  lo = condTrue(c, refFlags(a, b, f, paired));
  hi = paired ? condTrue(c, compareValues({48'b0, a[63:32]}, {48'b0, b[63:32]}, fmtSingle))
              : lo;
  if (paired || vec) return {vec ? ptypeDbl : ptypeSngl, {LANE_W{hi}}, {LANE_W{lo}}};
  else return '0;
endfunction

`endif

/* tests/fpCompareUnitTb.sv */
/*
  Testbench for the FP compare unit.
  Random scalar, paired and vector compares with zeros, infinities,
  NaNs and near pairs, checked one cycle later against the model.
*/
`timescale 1ns/1ns
`default_nettype none

module fpCompareUnitTb;

  import fpFormatPkg::*;
  import fpCmpPkg::*;

  `include "fpCmpModel.svh"

  localparam int NUM_OPS    = 3000;
  localparam int RST_CYCLES = 10;
  localparam int WAIT_LIMIT = 20;

  logic              clk, rst, paired, vec, maskValid;
  logic [OPER_W-1:0] opA, opB;
  fpFmt              fmt;
  cmpCond            cond;
  logic [3:0]        flags;
  logic [MASK_W-1:0] maskOut;
  logic [3:0]        expFlags;
  logic [MASK_W-1:0] expMask;
  logic              expValid;
  logic              expLive;     // expectation from a real compare
  logic              checkEn;
  integer            seed;
  int                waitCount;

  fpCompareUnit #(.MAG_WIDTH(MAG_W)) dut_i (
    .clk(clk), .rst(rst), .opA(opA), .opB(opB), .fmt(fmt), .paired(paired),
    .vec(vec), .cond(cond), .flags(flags), .maskOut(maskOut), .maskValid(maskValid)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic reportError(input string what);
    $display("ERROR: %s", what);
    $display("Simulation FAILED");
    $fatal(1, "test stopped");
  endtask

  task automatic reportMismatch(input string name, input logic [MASK_W-1:0] got,
                                input logic [MASK_W-1:0] want);
    $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, want);
    $display("Simulation FAILED");
    $fatal(1, "test stopped");
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // operand generation
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic logic [OPER_W-1:0] makeOperand(input fpFmt f);
    logic [31:0] r0, r1, r2, r3;
    logic [14:0] e;
    logic [62:0] fr;
    int          eMax;
    r0   = $random(seed);
    r1   = $random(seed);
    r2   = $random(seed);
    r3   = $random(seed);
    eMax = (f == fmtSingle) ? 255 : ((f == fmtDouble) ? 2047 : 32767);
    fr   = {r1[30:0], r0};
    case (int'(r3[3:0]))
      0:       begin e = '0; fr = '0; end         // zero of either sign
      1:       begin e = 15'(eMax); fr = '0; end  // infinity
      2:       begin e = 15'(eMax); fr = fr | 63'd1; end
      3:       e = '0;                            // denormal
      default: e = 15'(1 + (r2[30:0] % (eMax - 1)));
    endcase
    case (f)
      fmtSingle: return {r1, r2[15:0], r3[31], e[7:0], fr[22:0]};
      fmtDouble: return {r2[15:0], r3[31], e[10:0], fr[51:0]};
      default:   return {r3[31], e, (e != '0), fr};  // explicit integer bit
    endcase
  endfunction

  task automatic driveOp();
    logic [31:0]       r;
    logic [OPER_W-1:0] a, b, hiA, hiB, signFlip;
    fpFmt              f;
    logic              isPaired, isVec;
    r        = $random(seed);
    isPaired = (r[1:0] == 2'd1);
    isVec    = (r[1:0] == 2'd2);
    f        = (r[5:4] == 2'd0) ? fmtSingle : ((r[5:4] == 2'd1) ? fmtDouble : fmtExt);
    if (isVec) f = fmtDouble;
    signFlip = '0;
    if (isPaired) begin
      a   = makeOperand(fmtSingle);
      b   = makeOperand(fmtSingle);
      hiA = makeOperand(fmtSingle);
      hiB = makeOperand(fmtSingle);
      a   = {a[79:64], hiA[31:0], a[31:0]};
      b   = {b[79:64], hiB[31:0], b[31:0]};
      signFlip[31] = 1'b1;
      signFlip[63] = 1'b1;
    end else begin
      a = makeOperand(f);
      b = makeOperand(f);
      signFlip[(f == fmtSingle) ? 31 : ((f == fmtDouble) ? 63 : 79)] = 1'b1;
    end
    if (r[9:8] == 2'd1) b = a;               // equal pair
    else if (r[9:8] == 2'd2) b = a ^ signFlip;
    else if (r[9:8] == 2'd3) b = a ^ 80'd1;  // neighbour in the last place
    opA    <= a;
    opB    <= b;
    fmt    <= f;
    paired <= isPaired;
    vec    <= isVec;
    cond   <= cmpCond'(r[13:12]);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // expectation one cycle behind and checked mid-cycle
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always @(posedge clk) begin
    if (rst) begin
      expFlags <= '0;
      expMask  <= '0;
      expValid <= 1'b0;
      expLive  <= 1'b0;
    end else begin
      expFlags <= refFlags(opA, opB, fmt, paired);
      expMask  <= refMask(opA, opB, fmt, paired, vec, cond);
      expValid <= paired | vec;
      expLive  <= 1'b1;
    end
  end

  always @(negedge clk) begin
    if (checkEn) begin
      if (expLive) begin
        assert ($onehot(flags)) else reportError("ordering flags not exactly one-hot");
      end
      assert (flags === expFlags)
        else reportMismatch("flags", MASK_W'(flags), MASK_W'(expFlags));
      assert (maskOut === expMask) else reportMismatch("maskOut", maskOut, expMask);
      assert (maskValid === expValid)
        else reportMismatch("maskValid", MASK_W'(maskValid), MASK_W'(expValid));
    end
  end

  initial begin
    seed    = 65;
    checkEn = 1'b0;
    rst     = 1'b1;
    opA     = '0;
    opB     = '0;
    fmt     = fmtSingle;
    paired  = 1'b0;
    vec     = 1'b0;
    cond    = condEq;
    @(posedge clk);
    checkEn <= 1'b1;
    repeat (RST_CYCLES - 1) @(posedge clk);
    rst <= 1'b0;
    waitCount = 0;
    while (rst !== 1'b0) begin
      @(posedge clk);
      waitCount++;
      if (waitCount > WAIT_LIMIT) reportError("reset was not released in time");
    end
    for (int i = 0; i < NUM_OPS; i++) begin
      driveOp();                             // one per cycle back to back
      @(posedge clk);
    end
    for (int i = 0; i < 2; i++) @(posedge clk);
    @(negedge clk);
    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire
